// ==== source/ddr2_pkg.sv ====
package ddr2_pkg;

	// encoded as {RAS, CAS, WE}
	typedef enum logic [2:0] {
		NOOP = 3'b111,
		ACTV = 3'b011,
		READ = 3'b101,
		WRTE = 3'b100,
		BTRM = 3'b110,
		PRCH = 3'b010,
		ARSR = 3'b001,
		MRST = 3'b000
	} cmd_t;

	localparam int ROW_W = 14;
	localparam int COL_W = 10;
	localparam int BANK_W = 3;
	localparam int NUM_BANKS = 8;
	localparam int USER_ADDR_W = BANK_W + ROW_W + COL_W; // bank | row | col
	localparam logic [ROW_W-1:0] A10_ALL = 14'h400; // all banks / auto precharge

	typedef struct packed {
		cmd_t cmd;
		logic [ROW_W-1:0] addr;
		logic [BANK_W-1:0] bank;
	} init_step_t;

	localparam int INIT_STEPS = 11;

	function automatic init_step_t init_rom(input logic [3:0] idx);
		init_step_t s;
		case (idx)
			4'd0: s = '{PRCH, A10_ALL, 3'd1};
			4'd1: s = '{MRST, 14'h000, 3'd2}; // emr2
			4'd2: s = '{MRST, 14'h000, 3'd3}; // emr3
			4'd3: s = '{MRST, 14'h780, 3'd1}; // emr, ocd default
			4'd4: s = '{MRST, 14'h532, 3'd0}; // mr with dll reset
			4'd5: s = '{PRCH, A10_ALL, 3'd0};
			4'd6: s = '{ARSR, A10_ALL, 3'd0};
			4'd7: s = '{ARSR, A10_ALL, 3'd0};
			4'd8: s = '{MRST, 14'h432, 3'd0}; // mr, dll reset cleared
			4'd9: s = '{MRST, 14'h780, 3'd1};
			4'd10: s = '{MRST, 14'h400, 3'd1}; // ocd exit
			default: s = '{NOOP, A10_ALL, 3'd0};
		endcase
		return s;
	endfunction

endpackage

// ==== source/bank_if.sv ====
`timescale 1ns/1ns

interface bank_if;
	logic req_valid; // one-cycle strobe
	logic req_write;
	logic [ddr2_pkg::ROW_W-1:0] req_row;
	logic [ddr2_pkg::COL_W-1:0] req_col;
	logic cmd_req; // level, held until grant
	ddr2_pkg::cmd_t cmd;
	logic [ddr2_pkg::ROW_W-1:0] cmd_addr;
	logic grant; // one-cycle pulse
	logic slot_full;
	logic idle;
	logic close_all; // pulse after precharge-all

	modport splitter (output req_valid, req_write, req_row, req_col, input slot_full);

	modport bank (
		input req_valid, req_write, req_row, req_col, grant, close_all,
		output cmd_req, cmd, cmd_addr, slot_full, idle
	);

	modport sched (input cmd_req, cmd, cmd_addr, idle, output grant, close_all);

endinterface

// ==== source/ddr2_init.sv ====
`timescale 1ns/1ns

module ddr2_init #(
	parameter int CKE_WAIT = 65536,
	parameter int STEP_GAP = 32,
	parameter int SETTLE = 256
) (
	input logic CLK_n,
	input logic RST,
	input ddr2_pkg::cmd_t sched_cmd,
	input logic [ddr2_pkg::ROW_W-1:0] sched_addr,
	input logic [ddr2_pkg::BANK_W-1:0] sched_bank,
	output logic cke,
	output ddr2_pkg::cmd_t cmd_pin,
	output logic [ddr2_pkg::ROW_W-1:0] addr_pin,
	output logic [ddr2_pkg::BANK_W-1:0] ba_pin,
	output logic init_done
);

	localparam int CNT_W = $clog2(CKE_WAIT + STEP_GAP + SETTLE);

	typedef enum logic [1:0] {
		PH_CKE,
		PH_STEP,
		PH_SETTLE,
		PH_RUN
	} phase_t;

	phase_t phase;
	logic [CNT_W-1:0] cnt; // shared by all three waits
	logic [3:0] step;
	ddr2_pkg::init_step_t rom;
	ddr2_pkg::cmd_t init_cmd;
	logic [ddr2_pkg::ROW_W-1:0] init_addr;
	logic [ddr2_pkg::BANK_W-1:0] init_bank;

	assign rom = ddr2_pkg::init_rom(step);

	// scheduler owns the pins once init is done
	assign cmd_pin = init_done ? sched_cmd : init_cmd;
	assign addr_pin = init_done ? sched_addr : init_addr;
	assign ba_pin = init_done ? sched_bank : init_bank;

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			phase <= PH_CKE;
			cnt <= '0;
			step <= '0;
			cke <= 1'b0;
			init_done <= 1'b0;
			init_cmd <= ddr2_pkg::NOOP;
		end else begin
			init_cmd <= ddr2_pkg::NOOP; // nop between steps
			case (phase)
				PH_CKE: begin
					if (cnt == CNT_W'(CKE_WAIT - 1)) begin
						cke <= 1'b1;
						cnt <= '0;
						phase <= PH_STEP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				PH_STEP: begin
					if (cnt == CNT_W'(STEP_GAP - 1)) begin
						init_cmd <= rom.cmd; // on the pins for one cycle
						init_addr <= rom.addr;
						init_bank <= rom.bank;
						step <= step + 1'b1;
						cnt <= '0;
						if (step == 4'(ddr2_pkg::INIT_STEPS - 1)) begin
							phase <= PH_SETTLE;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				PH_SETTLE: begin
					if (cnt == CNT_W'(SETTLE - 1)) begin
						init_done <= 1'b1;
						phase <= PH_RUN;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					phase <= PH_RUN; // stays here until reset
				end
			endcase
		end
	end

endmodule

// ==== source/req_splitter.sv ====
`timescale 1ns/1ns

module req_splitter (
	input logic CLK_n,
	input logic RST,
	input logic req_valid,
	input logic req_write,
	input logic [ddr2_pkg::USER_ADDR_W-1:0] req_addr,
	input logic init_done,
	input logic refresh_pending,
	output logic ready,
	bank_if.splitter banks[ddr2_pkg::NUM_BANKS]
);

	logic [ddr2_pkg::BANK_W-1:0] req_bank;
	logic [ddr2_pkg::ROW_W-1:0] req_row;
	logic [ddr2_pkg::COL_W-1:0] req_col;
	logic accept;
	logic [ddr2_pkg::NUM_BANKS-1:0] valid_q;
	logic [ddr2_pkg::NUM_BANKS-1:0] slot_full;
	logic [ddr2_pkg::ROW_W-1:0] row_q;
	logic [ddr2_pkg::COL_W-1:0] col_q;
	logic write_q;

	assign {req_bank, req_row, req_col} = req_addr; // bank high, column low

	// an in-flight strobe counts as busy too, slot_full lags by a cycle
	assign ready = init_done && !refresh_pending && !(|slot_full) && !(|valid_q);
	assign accept = req_valid && ready;

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			valid_q <= '0;
		end else begin
			valid_q <= '0;
			if (accept) begin
				valid_q[req_bank] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_n) begin
		if (accept) begin
			row_q <= req_row;
			col_q <= req_col;
			write_q <= req_write;
		end
	end

	for (genvar i = 0; i < ddr2_pkg::NUM_BANKS; i++) begin : g_bank
		assign banks[i].req_valid = valid_q[i];
		assign banks[i].req_write = write_q; // payload shared, valid selects
		assign banks[i].req_row = row_q;
		assign banks[i].req_col = col_q;
		assign slot_full[i] = banks[i].slot_full;
	end

endmodule

// ==== source/bank_machine.sv ====
`timescale 1ns/1ns

module bank_machine #(
	parameter int T_RP = 4,
	parameter int T_RCD = 4
) (
	input logic CLK_n,
	input logic RST,
	bank_if.bank bus
);

	localparam int TMR_W = $clog2(T_RP + T_RCD + 1);

	typedef enum logic [1:0] {
		B_IDLE,
		B_PRE,
		B_ACT,
		B_COL
	} bstate_t;

	bstate_t state;
	logic [TMR_W-1:0] timer; // blocks cmd_req while nonzero
	logic open_valid;
	logic [ddr2_pkg::ROW_W-1:0] open_row;
	logic [ddr2_pkg::ROW_W-1:0] slot_row;
	logic [ddr2_pkg::COL_W-1:0] slot_col;
	logic slot_write;

	assign bus.slot_full = (state != B_IDLE);
	assign bus.idle = (state == B_IDLE) && !bus.req_valid;
	assign bus.cmd_req = (state != B_IDLE) && (timer == '0);

	always_comb begin
		case (state)
			B_PRE: begin
				bus.cmd = ddr2_pkg::PRCH;
				bus.cmd_addr = '0; // A10 low, this bank only
			end
			B_ACT: begin
				bus.cmd = ddr2_pkg::ACTV;
				bus.cmd_addr = slot_row;
			end
			B_COL: begin
				bus.cmd = slot_write ? ddr2_pkg::WRTE : ddr2_pkg::READ;
				bus.cmd_addr = ddr2_pkg::ROW_W'(slot_col); // no auto precharge
			end
			default: begin
				bus.cmd = ddr2_pkg::NOOP;
				bus.cmd_addr = '0;
			end
		endcase
	end

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			state <= B_IDLE;
			timer <= '0;
			open_valid <= 1'b0;
		end else begin
			if (timer != '0) begin
				timer <= timer - 1'b1;
			end
			if (bus.close_all) begin
				open_valid <= 1'b0; // rows closed by precharge-all
			end
			case (state)
				B_IDLE: begin
					if (bus.req_valid) begin
						slot_row <= bus.req_row;
						slot_col <= bus.req_col;
						slot_write <= bus.req_write;
						if (!open_valid) begin
							state <= B_ACT;
						end else if (open_row == bus.req_row) begin
							state <= B_COL; // row hit
						end else begin
							state <= B_PRE; // conflict
						end
					end
				end
				B_PRE: begin
					if (bus.grant) begin
						open_valid <= 1'b0;
						timer <= TMR_W'(T_RP - 1);
						state <= B_ACT;
					end
				end
				B_ACT: begin
					if (bus.grant) begin
						open_valid <= 1'b1;
						open_row <= slot_row;
						timer <= TMR_W'(T_RCD - 1);
						state <= B_COL;
					end
				end
				default: begin
					if (bus.grant) begin
						state <= B_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// ==== source/cmd_scheduler.sv ====
`timescale 1ns/1ns

module cmd_scheduler #(
	parameter int T_RP = 4,
	parameter int T_RFC = 26,
	parameter int REFRESH_INTERVAL = 1560,
	parameter int NUM_BANKS = 8
) (
	input logic CLK_n,
	input logic RST,
	input logic init_done,
	output logic refresh_pending,
	output ddr2_pkg::cmd_t sched_cmd,
	output logic [ddr2_pkg::ROW_W-1:0] sched_addr,
	output logic [ddr2_pkg::BANK_W-1:0] sched_bank,
	bank_if.sched banks[NUM_BANKS]
);

	localparam int IDX_W = $clog2(NUM_BANKS);
	localparam int REF_W = $clog2(REFRESH_INTERVAL);
	localparam int WAIT_W = $clog2(T_RP + T_RFC + 1);

	typedef enum logic [1:0] {
		R_RUN,
		R_DRAIN,
		R_RP,
		R_RFC
	} rstate_t;

	logic [NUM_BANKS-1:0] req_vec;
	logic [NUM_BANKS-1:0] idle_vec;
	ddr2_pkg::cmd_t cmd_arr[NUM_BANKS];
	logic [ddr2_pkg::ROW_W-1:0] addr_arr[NUM_BANKS];
	logic [IDX_W-1:0] last; // last granted bank
	logic [IDX_W-1:0] gnt_idx;
	logic gnt_any;
	logic gnt_en;
	rstate_t rstate;
	logic [REF_W-1:0] ref_cnt;
	logic [WAIT_W-1:0] wait_cnt;
	logic close_pulse;

	// banks keep getting grants while draining, so their sequences finish
	assign gnt_en = init_done && (rstate == R_RUN || rstate == R_DRAIN);
	assign refresh_pending = (rstate != R_RUN);
	assign close_pulse = (rstate == R_RFC) && (wait_cnt == '0);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		assign req_vec[i] = banks[i].cmd_req;
		assign idle_vec[i] = banks[i].idle;
		assign cmd_arr[i] = banks[i].cmd;
		assign addr_arr[i] = banks[i].cmd_addr;
		assign banks[i].grant = gnt_en && gnt_any && (gnt_idx == IDX_W'(i));
		assign banks[i].close_all = close_pulse;
	end

	always_comb begin
		int unsigned j;
		gnt_any = 1'b0;
		gnt_idx = last;
		for (int k = 1; k <= NUM_BANKS; k++) begin
			j = (int'(last) + k) % NUM_BANKS; // search starts after last grant
			if (!gnt_any && req_vec[j]) begin
				gnt_any = 1'b1;
				gnt_idx = IDX_W'(j);
			end
		end
	end

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			rstate <= R_RUN;
			ref_cnt <= '0;
			wait_cnt <= '0;
			last <= IDX_W'(NUM_BANKS - 1);
			sched_cmd <= ddr2_pkg::NOOP;
		end else begin
			sched_cmd <= ddr2_pkg::NOOP;
			if (init_done) begin
				ref_cnt <= (ref_cnt == REF_W'(REFRESH_INTERVAL - 1)) ? '0 : ref_cnt + 1'b1;
			end
			if (gnt_en && gnt_any) begin
				sched_cmd <= cmd_arr[gnt_idx];
				sched_addr <= addr_arr[gnt_idx];
				sched_bank <= ddr2_pkg::BANK_W'(gnt_idx);
				last <= gnt_idx;
			end
			case (rstate)
				R_RUN: begin
					if (init_done && ref_cnt == REF_W'(REFRESH_INTERVAL - 1)) begin
						rstate <= R_DRAIN;
					end
				end
				R_DRAIN: begin
					if (&idle_vec) begin
						sched_cmd <= ddr2_pkg::PRCH; // precharge all
						sched_addr <= ddr2_pkg::A10_ALL;
						sched_bank <= '0;
						wait_cnt <= WAIT_W'(T_RP - 1);
						rstate <= R_RP;
					end
				end
				R_RP: begin
					if (wait_cnt == '0) begin
						sched_cmd <= ddr2_pkg::ARSR;
						sched_addr <= ddr2_pkg::A10_ALL;
						sched_bank <= '0;
						wait_cnt <= WAIT_W'(T_RFC - 1);
						rstate <= R_RFC;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				default: begin
					if (wait_cnt == '0) begin
						rstate <= R_RUN; // close_pulse fires this cycle
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// ==== source/ddr2_ctrl_top.sv ====
`timescale 1ns/1ns

module ddr2_ctrl_top #(
	parameter int CKE_WAIT = 65536,
	parameter int STEP_GAP = 32,
	parameter int SETTLE = 256,
	parameter int T_RP = 4,
	parameter int T_RCD = 4,
	parameter int T_RFC = 26,
	parameter int REFRESH_INTERVAL = 1560
) (
	input logic CLK_n,
	input logic RST,
	input logic req_valid,
	input logic req_write,
	input logic [ddr2_pkg::USER_ADDR_W-1:0] req_addr,
	output logic ready,
	output logic cke,
	output ddr2_pkg::cmd_t cmd_pin,
	output logic [ddr2_pkg::ROW_W-1:0] addr_pin,
	output logic [ddr2_pkg::BANK_W-1:0] ba_pin,
	output logic init_done
);

	ddr2_pkg::cmd_t sched_cmd;
	logic [ddr2_pkg::ROW_W-1:0] sched_addr;
	logic [ddr2_pkg::BANK_W-1:0] sched_bank;
	logic refresh_pending;

	bank_if banks[ddr2_pkg::NUM_BANKS] ();

	ddr2_init #(
		.CKE_WAIT(CKE_WAIT),
		.STEP_GAP(STEP_GAP),
		.SETTLE(SETTLE)
	) i_ddr2_init (
		.CLK_n(CLK_n),
		.RST(RST),
		.sched_cmd(sched_cmd),
		.sched_addr(sched_addr),
		.sched_bank(sched_bank),
		.cke(cke),
		.cmd_pin(cmd_pin),
		.addr_pin(addr_pin),
		.ba_pin(ba_pin),
		.init_done(init_done)
	);

	req_splitter i_req_splitter (
		.CLK_n(CLK_n),
		.RST(RST),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.init_done(init_done),
		.refresh_pending(refresh_pending),
		.ready(ready),
		.banks(banks)
	);

	for (genvar i = 0; i < ddr2_pkg::NUM_BANKS; i++) begin : g_bank
		bank_machine #(
			.T_RP(T_RP),
			.T_RCD(T_RCD)
		) i_bank_machine (
			.CLK_n(CLK_n),
			.RST(RST),
			.bus(banks[i])
		);
	end

	cmd_scheduler #(
		.T_RP(T_RP),
		.T_RFC(T_RFC),
		.REFRESH_INTERVAL(REFRESH_INTERVAL),
		.NUM_BANKS(ddr2_pkg::NUM_BANKS)
	) i_cmd_scheduler (
		.CLK_n(CLK_n),
		.RST(RST),
		.init_done(init_done),
		.refresh_pending(refresh_pending),
		.sched_cmd(sched_cmd),
		.sched_addr(sched_addr),
		.sched_bank(sched_bank),
		.banks(banks)
	);

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 8,
	parameter int RST_CYCLES = 10
) (
	output logic CLK_n,
	output logic RST
);

	initial begin
		CLK_n = 1'b0;
		forever #(PERIOD / 2) CLK_n = ~CLK_n;
	end

	initial begin
		RST = 1'b0; // active low
		repeat (RST_CYCLES) @(posedge CLK_n);
		RST <= 1'b1; // released on a rising edge
	end

endmodule

// ==== testbench/tb_ddr2_ctrl.sv ====
`timescale 1ns/1ns

module tb_ddr2_ctrl;

	localparam int CKE_WAIT = 64;
	localparam int STEP_GAP = 32;
	localparam int SETTLE = 256;
	localparam int T_RP = 4;
	localparam int T_RCD = 4;
	localparam int T_RFC = 26;
	localparam int REFRESH_INTERVAL = 1560;
	localparam int NUM_INIT = 11;
	localparam int WATCHDOG_CYCLES = 10 + CKE_WAIT + STEP_GAP * (NUM_INIT + 1) + SETTLE
		+ 2 * REFRESH_INTERVAL + 16 * 100 + 1000;

	typedef struct {
		ddr2_pkg::cmd_t cmd;
		logic [ddr2_pkg::ROW_W-1:0] addr;
		logic [ddr2_pkg::BANK_W-1:0] bank;
		int cyc; // seen cycle, or earliest allowed cycle when expected
	} bus_cmd_t;

	logic CLK_n;
	logic RST;
	logic req_valid;
	logic req_write;
	logic [ddr2_pkg::USER_ADDR_W-1:0] req_addr;
	logic ready;
	logic cke;
	ddr2_pkg::cmd_t cmd_pin;
	logic [ddr2_pkg::ROW_W-1:0] addr_pin;
	logic [ddr2_pkg::BANK_W-1:0] ba_pin;
	logic init_done;

	int cyc = 0;
	int ref_count = 0;
	int ref_prch_cyc = -1;
	logic [31:0] lcg_state;
	bus_cmd_t seen[$]; // init commands from the pins
	bus_cmd_t exp_q[$]; // expected commands of all banks
	logic [ddr2_pkg::NUM_BANKS-1:0] row_open; // reference model
	logic [ddr2_pkg::ROW_W-1:0] open_row[ddr2_pkg::NUM_BANKS];
	ddr2_pkg::cmd_t last_cmd[ddr2_pkg::NUM_BANKS];
	int last_cyc[ddr2_pkg::NUM_BANKS];

	tb_clock #(.PERIOD(8), .RST_CYCLES(10)) i_tb_clock (.CLK_n(CLK_n), .RST(RST));

	ddr2_ctrl_top #(
		.CKE_WAIT(CKE_WAIT),
		.STEP_GAP(STEP_GAP),
		.SETTLE(SETTLE),
		.T_RP(T_RP),
		.T_RCD(T_RCD),
		.T_RFC(T_RFC),
		.REFRESH_INTERVAL(REFRESH_INTERVAL)
	) i_ddr2_ctrl_top (
		.CLK_n(CLK_n),
		.RST(RST),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.ready(ready),
		.cke(cke),
		.cmd_pin(cmd_pin),
		.addr_pin(addr_pin),
		.ba_pin(ba_pin),
		.init_done(init_done)
	);

	always @(posedge CLK_n) cyc <= cyc + 1;

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic timed_out(input string what);
		$display("Timed out waiting for %s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// DDR2 power-up sequence, in order
	function automatic ddr2_pkg::init_step_t expected_init(input int k);
		case (k)
			0: return {ddr2_pkg::PRCH, 14'h400, 3'd1};
			1: return {ddr2_pkg::MRST, 14'h000, 3'd2};
			2: return {ddr2_pkg::MRST, 14'h000, 3'd3};
			3: return {ddr2_pkg::MRST, 14'h780, 3'd1};
			4: return {ddr2_pkg::MRST, 14'h532, 3'd0};
			5: return {ddr2_pkg::PRCH, 14'h400, 3'd0};
			6: return {ddr2_pkg::ARSR, 14'h400, 3'd0};
			7: return {ddr2_pkg::ARSR, 14'h400, 3'd0};
			8: return {ddr2_pkg::MRST, 14'h432, 3'd0};
			9: return {ddr2_pkg::MRST, 14'h780, 3'd1};
			default: return {ddr2_pkg::MRST, 14'h400, 3'd1};
		endcase
	endfunction

	function automatic void push_exp(input ddr2_pkg::cmd_t cmd, input logic [13:0] addr,
		input logic [2:0] bank, input int earliest);
		exp_q.push_back('{cmd, addr, bank, earliest});
	endfunction

	function automatic int pending_for(input logic [2:0] bank);
		int n;
		n = 0;
		foreach (exp_q[i]) begin
			if (exp_q[i].bank == bank) n++;
		end
		return n;
	endfunction

	task automatic check_bus_cmd(input bus_cmd_t r);
		bus_cmd_t e;
		int idx;
		idx = -1;
		if (r.cmd == ddr2_pkg::PRCH && r.addr == 14'h400) begin
			assert (exp_q.size() == 0) else report_error("precharge-all with bank work pending");
			row_open = '0; // every row closed
			ref_prch_cyc = r.cyc;
		end else if (r.cmd == ddr2_pkg::ARSR) begin
			assert (ref_prch_cyc >= 0 && r.cyc - ref_prch_cyc >= T_RP)
				else report_error("refresh without tRP after precharge-all");
			ref_prch_cyc = -1;
			ref_count++;
		end else begin
			foreach (exp_q[i]) begin
				if (idx < 0 && exp_q[i].bank == r.bank) idx = i; // oldest for this bank
			end
			assert (idx >= 0)
				else report_error($sformatf("unexpected %s on bank %0d", r.cmd.name(), r.bank));
			e = exp_q[idx];
			assert (r.cmd == e.cmd && r.addr == e.addr) else report_error($sformatf(
				"bank %0d expected %s 0x%0h, got %s 0x%0h",
				r.bank, e.cmd.name(), e.addr, r.cmd.name(), r.addr));
			assert (r.cyc >= e.cyc) else report_error("command too soon after request");
			if (r.cmd == ddr2_pkg::ACTV && last_cmd[r.bank] == ddr2_pkg::PRCH) begin
				assert (r.cyc - last_cyc[r.bank] >= T_RP) else report_error("tRP violated");
			end
			if (r.cmd != ddr2_pkg::ACTV && last_cmd[r.bank] == ddr2_pkg::ACTV) begin
				assert (r.cyc - last_cyc[r.bank] >= T_RCD) else report_error("tRCD violated");
			end
			last_cmd[r.bank] = r.cmd;
			last_cyc[r.bank] = r.cyc;
			exp_q.delete(idx);
		end
	endtask

	// pin monitor samples mid-cycle
	always @(negedge CLK_n) begin
		if (RST && cmd_pin != ddr2_pkg::NOOP) begin
			if (!init_done) begin
				seen.push_back('{cmd_pin, addr_pin, ba_pin, cyc});
			end else begin
				check_bus_cmd('{cmd_pin, addr_pin, ba_pin, cyc});
			end
		end
	end

	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge CLK_n);
		while (!ready) begin
			assert (n < 200) else timed_out("ready");
			n++;
			@(negedge CLK_n);
		end
	endtask

	task automatic wait_bank_done(input logic [2:0] bank);
		int n;
		n = 0;
		while (pending_for(bank) > 0) begin
			assert (n < 200) else timed_out($sformatf("bank %0d commands", bank));
			n++;
			@(negedge CLK_n);
		end
	endtask

	task automatic issue_req(input logic [2:0] bank, input logic [13:0] row,
		input logic [9:0] col, input logic write);
		ddr2_pkg::cmd_t col_cmd;
		int first;
		col_cmd = write ? ddr2_pkg::WRTE : ddr2_pkg::READ;
		wait_ready();
		@(posedge CLK_n);
		req_valid <= 1'b1;
		req_write <= write;
		req_addr <= {bank, row, col};
		wait_ready();
		@(posedge CLK_n); // accepted on this edge
		req_valid <= 1'b0;
		first = cyc + 3; // splitter register, bank, scheduler
		if (row_open[bank] && open_row[bank] == row) begin
			push_exp(col_cmd, {4'b0, col}, bank, first);
		end else begin
			if (row_open[bank]) begin
				push_exp(ddr2_pkg::PRCH, '0, bank, first); // A10 low
				first = 0;
			end
			push_exp(ddr2_pkg::ACTV, row, bank, first);
			push_exp(col_cmd, {4'b0, col}, bank, 0);
		end
		row_open[bank] = 1'b1;
		open_row[bank] = row;
	endtask

	task automatic take_init_cmd(output bus_cmd_t r, input int limit);
		int n;
		n = 0;
		while (seen.size() == 0) begin
			assert (n < limit) else timed_out("an init command");
			n++;
			@(negedge CLK_n);
		end
		r = seen.pop_front();
	endtask

	task automatic verify_init_sequence();
		bus_cmd_t r;
		ddr2_pkg::init_step_t e;
		int rst_cyc;
		int prev_cyc;
		@(negedge CLK_n);
		while (!RST) @(negedge CLK_n);
		rst_cyc = cyc;
		assert (!cke && cmd_pin == ddr2_pkg::NOOP && !init_done && !ready)
			else report_error("outputs not idle after reset");
		while (!cke) begin
			assert (cyc - rst_cyc <= CKE_WAIT) else timed_out("cke");
			@(negedge CLK_n);
		end
		assert (cyc - rst_cyc == CKE_WAIT) else report_error("cke rose at the wrong cycle");
		prev_cyc = cyc;
		for (int k = 0; k < NUM_INIT; k++) begin
			take_init_cmd(r, STEP_GAP + 4);
			e = expected_init(k);
			assert (r.cmd == e.cmd && r.addr == e.addr && r.bank == e.bank)
				else report_error($sformatf("init step %0d got %s 0x%0h bank %0d",
					k + 1, r.cmd.name(), r.addr, r.bank));
			assert (k == 0 || r.cyc - prev_cyc == STEP_GAP)
				else report_error($sformatf("init step %0d spacing wrong", k + 1));
			prev_cyc = r.cyc;
		end
		while (!init_done) begin
			assert (cyc - prev_cyc <= SETTLE) else timed_out("init_done");
			@(negedge CLK_n);
		end
		assert (cyc - prev_cyc == SETTLE) else report_error("init_done at the wrong cycle");
		assert (seen.size() == 0) else report_error("extra command on the pins during init");
	endtask

	task automatic write_closed_row();
		issue_req(3'd2, 14'h0123, 10'h040, 1'b1); // ACTV then WRTE
		wait_bank_done(3'd2);
	endtask

	task automatic read_row_hit();
		issue_req(3'd2, 14'h0123, 10'h080, 1'b0); // READ only
		wait_bank_done(3'd2);
	endtask

	task automatic read_row_conflict();
		issue_req(3'd2, 14'h02aa, 10'h010, 1'b0); // PRCH, ACTV, READ
		wait_bank_done(3'd2);
	endtask

	task automatic interleave_banks();
		logic [31:0] v;
		int n;
		for (int i = 0; i < ddr2_pkg::NUM_BANKS; i++) begin
			v = lcg_next();
			issue_req(3'(i), v[27:14], v[9:0], v[31]);
		end
		n = 0;
		while (exp_q.size() > 0) begin
			assert (n < 400) else timed_out("interleaved requests");
			n++;
			@(negedge CLK_n);
		end
	endtask

	task automatic refresh_closes_rows();
		int start_count;
		int n;
		issue_req(3'd5, 14'h0155, 10'h020, 1'b0);
		wait_bank_done(3'd5);
		start_count = ref_count;
		n = 0;
		while (ref_count == start_count) begin
			assert (n < 2 * REFRESH_INTERVAL) else timed_out("a refresh");
			n++;
			@(negedge CLK_n);
		end
		issue_req(3'd5, 14'h0155, 10'h024, 1'b1); // needs ACTV again
		wait_bank_done(3'd5);
	endtask

	initial begin
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		lcg_state = 32'd95080;
		row_open = '0;
		foreach (last_cmd[b]) begin
			last_cmd[b] = ddr2_pkg::NOOP;
			last_cyc[b] = 0;
		end
		verify_init_sequence();
		write_closed_row();
		read_row_hit();
		read_row_conflict();
		interleave_banks();
		refresh_closes_rows();
		repeat (4) @(posedge CLK_n);
		$display("Regression passed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK_n);
		$display("Watchdog expired before the tests finished");
		$display("Regression failed");
		$fatal(1);
	end

endmodule

// ==== all.f ====
source/ddr2_pkg.sv
source/bank_if.sv
source/ddr2_init.sv
source/req_splitter.sv
source/bank_machine.sv
source/cmd_scheduler.sv
source/ddr2_ctrl_top.sv
testbench/tb_clock.sv
testbench/tb_ddr2_ctrl.sv

// ==== Bender.yml ====
package:
  name: ddr2_ctrl

sources:
  - files:
      - source/ddr2_pkg.sv
      - source/bank_if.sv
      - source/ddr2_init.sv
      - source/req_splitter.sv
      - source/bank_machine.sv
      - source/cmd_scheduler.sv
      - source/ddr2_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_ddr2_ctrl.sv
